/* Makefile */
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f tb.f --top-module trellisMonitorTb -o simv

run: compile
	-./obj_dir/simv > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* bench/monitorVectors.svh */
/* limiter stimulus with expected limited values, and the monitor
   select rows applied to the three DAC channels */

// ------------------------------------------------------------
// limiter vectors
// ------------------------------------------------------------
// raw is the 10-bit signed phase error, lim the expected 8-bit result
typedef struct packed {
  logic [9:0] raw;
  logic [7:0] lim;
} limitVecT;

localparam int limitCount  = 8;
// random samples appended after the fixed ones
localparam int randomCount = 8;

localparam limitVecT limitTable [limitCount] = '{
  '{raw: 10'h07f, lim: 8'h7f},  // 127 passes
  '{raw: 10'h080, lim: 8'h7f},  // 128 clips high
  '{raw: 10'h380, lim: 8'h80},  // -128 passes
  '{raw: 10'h37f, lim: 8'h81},  // -129 clips to -127
  '{raw: 10'h000, lim: 8'h00},
  '{raw: 10'h1ff, lim: 8'h7f},  // largest positive
  '{raw: 10'h200, lim: 8'h81},  // most negative
  '{raw: 10'h3ff, lim: 8'hff}   // -1
};

// ------------------------------------------------------------
// monitor select rows
// ------------------------------------------------------------
// one source code per channel, code 9 is unused
typedef struct packed {
  logic [3:0] sel0;
  logic [3:0] sel1;
  logic [3:0] sel2;
} muxRowT;

localparam int muxRowCount = 6;
// cycles each row is held with fresh random inputs
localparam int muxRepeat   = 8;

// rotated so every code lands on every channel
localparam muxRowT muxTable [muxRowCount] = '{
  '{sel0: 4'd0, sel1: 4'd1, sel2: 4'd2},
  '{sel0: 4'd1, sel1: 4'd2, sel2: 4'd3},
  '{sel0: 4'd2, sel1: 4'd3, sel2: 4'd4},
  '{sel0: 4'd3, sel1: 4'd4, sel2: 4'd9},
  '{sel0: 4'd4, sel1: 4'd9, sel2: 4'd0},
  '{sel0: 4'd9, sel1: 4'd0, sel2: 4'd1}
};

/* bench/trellisMonitorTb.sv */
/* trellis monitor testbench with reset, strobe tap, output strobe,
   phase limiter and DAC monitor channel checks */

`timescale 1ns/1ps

module trellisMonitorTb;

  import trellisPkg::*;

  `include "monitorVectors.svh"

  localparam int timeoutCycles = (limitCount + randomCount + muxRowCount) * 20 + 200;

  logic                   clk;
  logic                   rstN;
  logic                   symEn;
  logic                   sym2xEn;
  iqSampleT               loopIq;
  logic [freqWidth-1:0]   freq;
  logic [rawErrWidth-1:0] rawPhaseErr;
  logic                   phaseStrobe;
  logic [indexWidth-1:0]  index;
  logic                   decoderSymEn;
  dacSrcT                 dacSelect [3];
  logic                   rotEna;
  logic                   trellEna;
  logic                   sym2xEnOut;
  logic [errWidth-1:0]    phErr;
  dacChanT                dac [3];

  int cycleCount = 0;

  // limiter model state used by the limiter and mux tests
  logic [7:0] expPh;
  logic [9:0] pendingRaw;
  logic [7:0] pendingExp;

  trellisMonitor trellisMonitor_inst (
    .clk          (clk),
    .rstN         (rstN),
    .symEn        (symEn),
    .sym2xEn      (sym2xEn),
    .loopIq       (loopIq),
    .freq         (freq),
    .rawPhaseErr  (rawPhaseErr),
    .phaseStrobe  (phaseStrobe),
    .index        (index),
    .decoderSymEn (decoderSymEn),
    .dacSelect    (dacSelect),
    .rotEna       (rotEna),
    .trellEna     (trellEna),
    .sym2xEnOut   (sym2xEnOut),
    .phErr        (phErr),
    .dac          (dac)
  );

  // ------------------------------------------------------------
  // clock and timeout
  // ------------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      $display("timeout, the tests did not finish within %0d cycles", timeoutCycles);
      $display("** FAIL **");
      $fatal(1, "simulation timed out");
    end
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic checkEq(input string name, input logic [31:0] expVal,
                         input logic [31:0] actVal);
    if (expVal !== actVal) begin
      $display("** Error %s: expected %0h, actual %0h", name, expVal, actVal);
      $display("** FAIL **");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // -128..127 pass unchanged and the rest clip to +-127
  function automatic logic [7:0] limitErr(input logic [9:0] raw);
    logic signed [9:0] v;
    v = raw;
    if (v > 10'sd127) begin
      return 8'h7f;
    end else if (v < -10'sd128) begin
      return 8'h81;
    end else begin
      return raw[7:0];
    end
  endfunction

  // left-aligned DAC word for each source code
  function automatic logic [17:0] dacData(input logic [3:0] sel, input iqSampleT iq,
                                          input logic [7:0] ph, input logic [4:0] idx,
                                          input logic [7:0] fr);
    case (sel)
      4'd0: return iq.i;
      4'd1: return iq.q;
      4'd3: return {1'b0, idx, 12'b0};
      4'd4: return {fr, 10'b0};
      default: return {ph, 10'b0};
    endcase
  endfunction

  function automatic logic dacSync(input logic [3:0] sel, input logic s2x,
                                   input logic ph, input logic tr);
    case (sel)
      4'd0, 4'd1, 4'd4: return s2x;
      4'd3: return tr;
      default: return ph;
    endcase
  endfunction

  task automatic checkIdleOutputs(input string name);
    checkEq({name, " rotEna"}, 32'd0, 32'(rotEna));
    checkEq({name, " trellEna"}, 32'd0, 32'(trellEna));
    checkEq({name, " sym2xEnOut"}, 32'd0, 32'(sym2xEnOut));
    checkEq({name, " phErr"}, 32'd0, 32'(phErr));
    for (int c = 0; c < 3; c++) begin
      checkEq($sformatf("%s dac%0d sync", name, c), 32'd0, 32'(dac[c].sync));
      checkEq($sformatf("%s dac%0d data", name, c), 32'd0, 32'(dac[c].data));
    end
  endtask

  // ------------------------------------------------------------
  // strobe tests
  // ------------------------------------------------------------
  // one marker cycle then both taps followed for 14 cycles
  task automatic markerTest(input logic symBit, input logic expectTaps);
    @(posedge clk);
    symEn   <= symBit;
    sym2xEn <= 1'b1;
    for (int n = 1; n <= 14; n++) begin
      @(posedge clk);
      symEn   <= 1'b0;
      sym2xEn <= 1'b0;
      @(negedge clk);
      checkEq($sformatf("marker rotEna cycle %0d", n),
              32'(expectTaps && n == 5), 32'(rotEna));
      checkEq($sformatf("marker trellEna cycle %0d", n),
              32'(expectTaps && n == 11), 32'(trellEna));
    end
  endtask

  task automatic outStrobeTest();
    @(posedge clk);
    decoderSymEn <= 1'b1;
    for (int n = 1; n <= 4; n++) begin
      @(posedge clk);
      decoderSymEn <= 1'b0;
      @(negedge clk);
      checkEq($sformatf("sym2xEnOut cycle %0d", n),
              32'(n == 1 || n == 2), 32'(sym2xEnOut));
    end
  endtask

  // ------------------------------------------------------------
  // limiter test
  // ------------------------------------------------------------
  task automatic strobePhase(input logic [9:0] raw, input logic [7:0] rawLim,
                             input string name);
    @(posedge clk);
    phaseStrobe <= 1'b1;
    rawPhaseErr <= raw;
    @(posedge clk);
    phaseStrobe <= 1'b0;
    @(negedge clk);
    // previous sample comes out on this strobe
    checkEq(name, 32'(pendingExp), 32'(phErr));
    expPh      = pendingExp;
    pendingExp = rawLim;
    pendingRaw = raw;
  endtask

  task automatic limiterTest();
    logic [31:0] rnd;
    logic [9:0]  raw;
    for (int i = 0; i < limitCount; i++) begin
      strobePhase(limitTable[i].raw, limitTable[i].lim,
                  $sformatf("limiter fixed %0d", i));
    end
    for (int i = 0; i < randomCount; i++) begin
      rnd = $urandom;
      raw = rnd[9:0];
      strobePhase(raw, limitErr(raw), $sformatf("limiter random %0d", i));
    end
    // flush the last sample out
    strobePhase(10'h000, 8'h00, "limiter flush");
  endtask

  // ------------------------------------------------------------
  // DAC mux test
  // ------------------------------------------------------------
  task automatic muxTest();
    logic [31:0] rnd;
    logic [15:0] markerHist;
    logic        prevStrobe;
    logic [9:0]  prevRaw;
    logic        trExp;
    logic [3:0]  sel [3];
    logic [17:0] curData [3];
    logic        curSync [3];
    logic [17:0] prevData [3];
    logic        prevSync [3];
    iqSampleT    iq;
    logic        s2x;
    logic        sEn;
    logic        ph;
    logic [9:0]  raw;
    logic [4:0]  idx;
    logic [7:0]  fr;
    int          steps;
    int          row;
    markerHist = '0;
    prevStrobe = 1'b0;
    prevRaw    = '0;
    steps      = muxRowCount * muxRepeat;
    for (int t = 0; t <= steps; t++) begin
      @(posedge clk);
      if (t < steps) begin
        // strobe from last step has just moved the limiter
        if (prevStrobe) begin
          expPh      = limitErr(pendingRaw);
          pendingRaw = prevRaw;
        end
        // trellis sync is the marker from 11 cycles back
        trExp = markerHist[10];
        row   = t / muxRepeat;
        sel[0] = muxTable[row].sel0;
        sel[1] = muxTable[row].sel1;
        sel[2] = muxTable[row].sel2;
        rnd = $urandom;
        iq.i = rnd[17:0];
        rnd = $urandom;
        iq.q = rnd[17:0];
        rnd = $urandom;
        fr  = rnd[7:0];
        idx = rnd[12:8];
        raw = rnd[22:13];
        s2x = rnd[23];
        sEn = rnd[24];
        ph  = rnd[25];
        for (int c = 0; c < 3; c++) begin
          curData[c] = dacData(sel[c], iq, expPh, idx, fr);
          curSync[c] = dacSync(sel[c], s2x, ph, trExp);
        end
        markerHist = {markerHist[14:0], s2x & ~sEn};
        prevStrobe = ph;
        prevRaw    = raw;
        loopIq      <= iq;
        freq        <= fr;
        index       <= idx;
        rawPhaseErr <= raw;
        sym2xEn     <= s2x;
        symEn       <= sEn;
        phaseStrobe <= ph;
        for (int c = 0; c < 3; c++) begin
          dacSelect[c] <= dacSrcT'(sel[c]);
        end
      end else begin
        sym2xEn     <= 1'b0;
        symEn       <= 1'b0;
        phaseStrobe <= 1'b0;
      end
      @(negedge clk);
      if (t > 0) begin
        for (int c = 0; c < 3; c++) begin
          checkEq($sformatf("mux step %0d dac%0d data", t - 1, c),
                  32'(prevData[c]), 32'(dac[c].data));
          checkEq($sformatf("mux step %0d dac%0d sync", t - 1, c),
                  32'(prevSync[c]), 32'(dac[c].sync));
        end
      end
      for (int c = 0; c < 3; c++) begin
        prevData[c] = curData[c];
        prevSync[c] = curSync[c];
      end
    end
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(32'hc688));
    expPh        = '0;
    pendingRaw   = '0;
    pendingExp   = '0;
    rstN         = 1'b0;
    symEn        = 1'b0;
    sym2xEn      = 1'b0;
    loopIq       = '0;
    freq         = '0;
    rawPhaseErr  = '0;
    phaseStrobe  = 1'b0;
    index        = '0;
    decoderSymEn = 1'b0;
    for (int c = 0; c < 3; c++) begin
      dacSelect[c] = srcTrellisI;
    end

    // outputs stay quiet while reset is held for 10 cycles
    for (int n = 0; n < 10; n++) begin
      @(negedge clk);
      checkIdleOutputs("reset");
    end
    @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    checkIdleOutputs("after reset");

    markerTest(1'b0, 1'b1);
    // both strobes high is not a marker
    markerTest(1'b1, 1'b0);
    outStrobeTest();
    outStrobeTest();
    limiterTest();

    // let the marker line drain before the mux test
    repeat (20) @(posedge clk);
    muxTest();

    $display("** PASS **");
    $finish;
  end

endmodule

/* hw/dacMonitorMux.sv */
/* one registered DAC monitor channel, picks a source word and
   its sync strobe, data left-aligned in the DAC word */

`timescale 1ns/1ps

module dacMonitorMux (
  input  logic                    clk,
  input  logic                    rstN,
  input  trellisPkg::dacSrcT      select,
  input  trellisPkg::monitorSrcT  src,
  input  trellisPkg::monitorSyncT sync,
  output trellisPkg::dacChanT     chan
);

  import trellisPkg::*;

  // zero fill below the narrow sources
  localparam int errPad   = sampleWidth - errWidth;
  localparam int freqPad  = sampleWidth - freqWidth;
  // index sits one bit below the DAC msb
  localparam int indexPad = sampleWidth - indexWidth - 1;

  dacChanT nextChan;

  // ------------------------------------------------------------
  // source select
  // ------------------------------------------------------------
  always_comb begin
    case (select)
      srcTrellisI: begin
        nextChan.data = src.iq.i;
        nextChan.sync = sync.sample2x;
      end
      srcTrellisQ: begin
        nextChan.data = src.iq.q;
        nextChan.sync = sync.sample2x;
      end
      srcIndex: begin
        // keep msb clear so the index reads positive on the scope
        nextChan.data = {1'b0, src.index, {indexPad{1'b0}}};
        nextChan.sync = sync.trellis;
      end
      srcFreq: begin
        nextChan.data = {src.freq, {freqPad{1'b0}}};
        nextChan.sync = sync.sample2x;
      end
      // srcPhaseErr and every unused code
      default: begin
        nextChan.data = {src.phErr, {errPad{1'b0}}};
        nextChan.sync = sync.phase;
      end
    endcase
  end

  // ------------------------------------------------------------
  // output register, one cycle behind the inputs
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      chan <= '0;
    end else begin
      chan <= nextChan;
    end
  end

endmodule

/* hw/phaseErrLimiter.sv */
/* two-stage saturating limiter, 10-bit signed phase error
   down to 8 bits, advanced only on the phase strobe */

`timescale 1ns/1ps

module phaseErrLimiter (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic                              phaseStrobe,
  input  logic [trellisPkg::rawErrWidth-1:0] rawPhaseErr,
  output logic [trellisPkg::errWidth-1:0]    phErr
);

  import trellisPkg::*;

  // stage one holds the low bits and the overflow flags
  logic [errWidth-1:0] dataBits;
  logic                satPos;
  logic                satNeg;
  logic                sign;
  logic [1:0]          guardBits;

  assign sign      = rawPhaseErr[rawErrWidth-1];
  // bits above the 8-bit range plus its sign bit
  assign guardBits = rawPhaseErr[errWidth:errWidth-1];

  // ------------------------------------------------------------
  // two samples in flight, each strobe moves both stages
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      dataBits <= '0;
      satPos   <= 1'b0;
      satNeg   <= 1'b0;
      phErr    <= '0;
    end else if (phaseStrobe) begin
      // stage one, capture current sample
      dataBits <= rawPhaseErr[errWidth-1:0];
      // positive and guard bits not all zero, too big
      satPos   <= !sign && (guardBits != 2'b00);
      // negative and guard bits not all one, below -128
      satNeg   <= sign && (guardBits != 2'b11);
      // stage two, limit the previous sample
      if (satPos) begin
        phErr <= errPosLimit;
      end else if (satNeg) begin
        phErr <= errNegLimit;
      end else begin
        phErr <= dataBits;
      end
    end
  end

endmodule

/* hw/strobeTiming.sv */
/* symbol marker delay line with rotator and trellis taps,
   and the two-cycle output strobe built from the decoder strobe */

`timescale 1ns/1ps

module strobeTiming (
  input  logic clk,
  input  logic rstN,
  input  logic symEn,
  input  logic sym2xEn,
  input  logic decoderSymEn,
  output logic rotEna,
  output logic trellEna,
  output logic sym2xEnOut
);

  import trellisPkg::*;

  // ------------------------------------------------------------
  // symbol marker delay line
  // ------------------------------------------------------------
  // marker is the 2x strobe on the off phase of the 1x strobe
  logic                   marker;
  logic [markerDepth-1:0] markerShift;
  // decoder strobe delayed one cycle
  logic                   decoderSymDly;

  assign marker = sym2xEn && !symEn;

  // bit 0 holds the marker one cycle after it was seen
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      markerShift <= '0;
    end else begin
      markerShift <= {markerShift[markerDepth-2:0], marker};
    end
  end

  // tap n fires n+1 cycles after the marker cycle
  assign rotEna   = markerShift[rotTap];
  assign trellEna = markerShift[trellTap];

  // ------------------------------------------------------------
  // doubled output strobe
  // ------------------------------------------------------------
  // line decoder downstream wants a 2x enable
  // stretch each decoder pulse over the next two cycles
  // pulses are at least 3 cycles apart so they never merge
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      decoderSymDly <= 1'b0;
      sym2xEnOut    <= 1'b0;
    end else begin
      decoderSymDly <= decoderSymEn;
      sym2xEnOut    <= decoderSymDly | decoderSymEn;
    end
  end

endmodule

/* hw/trellisMonitor.sv */
/* trellis monitor top, strobe timing, phase error limiter
   and three DAC monitor channels */

`timescale 1ns/1ps

module trellisMonitor (
  input  logic                              clk,
  input  logic                              rstN,
  // symbol timing strobes
  input  logic                              symEn,
  input  logic                              sym2xEn,
  // carrier loop sample and frequency word
  input  trellisPkg::iqSampleT              loopIq,
  input  logic [trellisPkg::freqWidth-1:0]   freq,
  // decoder side
  input  logic [trellisPkg::rawErrWidth-1:0] rawPhaseErr,
  input  logic                              phaseStrobe,
  input  logic [trellisPkg::indexWidth-1:0]  index,
  input  logic                              decoderSymEn,
  // monitor channel selects
  input  trellisPkg::dacSrcT                dacSelect [3],
  // strobes to rotator and decoder
  output logic                              rotEna,
  output logic                              trellEna,
  output logic                              sym2xEnOut,
  output logic [trellisPkg::errWidth-1:0]    phErr,
  output trellisPkg::dacChanT               dac [3]
);

  import trellisPkg::*;

  monitorSrcT  monSrc;
  monitorSyncT monSync;

  // ------------------------------------------------------------
  // decode, symbol strobe taps
  // ------------------------------------------------------------
  strobeTiming strobeTiming_inst (
    .clk          (clk),
    .rstN         (rstN),
    .symEn        (symEn),
    .sym2xEn      (sym2xEn),
    .decoderSymEn (decoderSymEn),
    .rotEna       (rotEna),
    .trellEna     (trellEna),
    .sym2xEnOut   (sym2xEnOut)
  );

  // ------------------------------------------------------------
  // execute, phase error limit
  // ------------------------------------------------------------
  phaseErrLimiter phaseErrLimiter_inst (
    .clk         (clk),
    .rstN        (rstN),
    .phaseStrobe (phaseStrobe),
    .rawPhaseErr (rawPhaseErr),
    .phErr       (phErr)
  );

  // ------------------------------------------------------------
  // result, monitor channels
  // ------------------------------------------------------------
  // same source table for every channel
  assign monSrc.iq    = loopIq;
  assign monSrc.phErr = phErr;
  assign monSrc.index = index;
  assign monSrc.freq  = freq;

  // trellis sync follows the strobe sent to the decoder
  assign monSync.sample2x = sym2xEn;
  assign monSync.phase    = phaseStrobe;
  assign monSync.trellis  = trellEna;

  for (genvar ch = 0; ch < 3; ch++) begin : gDac
    dacMonitorMux dacMonitorMux_inst (
      .clk    (clk),
      .rstN   (rstN),
      .select (dacSelect[ch]),
      .src    (monSrc),
      .sync   (monSync),
      .chan   (dac[ch])
    );
  end

endmodule

/* hw/trellisPkg.sv */
/* widths, tap positions, limiter bounds, monitor source codes and the
   packed structs shared by the trellis monitor blocks */

package trellisPkg;

  // ------------------------------------------------------------
  // data widths
  // ------------------------------------------------------------
  // carrier loop I/Q and DAC word
  localparam int sampleWidth = 18;
  // phase error straight from the decoder
  localparam int rawErrWidth = 10;
  // limited phase error
  localparam int errWidth    = 8;
  localparam int indexWidth  = 5;
  localparam int freqWidth   = 8;

  // ------------------------------------------------------------
  // symbol marker taps
  // ------------------------------------------------------------
  localparam int rotTap      = 4;
  localparam int trellTap    = 10;
  localparam int markerDepth = 16;

  // limiter bounds, symmetric around zero
  localparam logic signed [errWidth-1:0] errPosLimit = 8'sd127;
  localparam logic signed [errWidth-1:0] errNegLimit = -8'sd127;

  // monitor source codes, unlisted codes fall back to phase error
  typedef enum logic [3:0] {
    srcTrellisI = 4'd0,
    srcTrellisQ = 4'd1,
    srcPhaseErr = 4'd2,
    srcIndex    = 4'd3,
    srcFreq     = 4'd4
  } dacSrcT;

  typedef struct packed {
    logic [sampleWidth-1:0] i;
    logic [sampleWidth-1:0] q;
  } iqSampleT;

  // everything a monitor channel can pick from
  typedef struct packed {
    iqSampleT              iq;
    logic [errWidth-1:0]   phErr;
    logic [indexWidth-1:0] index;
    logic [freqWidth-1:0]  freq;
  } monitorSrcT;

  // strobes that mark valid samples of each source
  typedef struct packed {
    logic sample2x;
    logic phase;
    logic trellis;
  } monitorSyncT;

  typedef struct packed {
    logic                   sync;
    logic [sampleWidth-1:0] data;
  } dacChanT;

endpackage

/* tb.f */
+incdir+bench
hw/trellisPkg.sv
hw/strobeTiming.sv
hw/phaseErrLimiter.sv
hw/dacMonitorMux.sv
hw/trellisMonitor.sv
bench/trellisMonitorTb.sv
